/* Bender.yml */
package:
  name: yarc_platform

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/platform_pkg.sv
      - design/wb_addr_decoder.sv
      - design/dmem.sv
      - design/mtimer.sv
      - design/led_driver.sv
      - design/yarc_platform.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/tb_yarc_platform.sv

/* design/dmem.sv */
// word memory indexed by addr bits 11:2, contents come up undefined
// read data is the old word on a same-address write, zero on writes
`timescale 1ns/10ps
`default_nettype none

`include "platform_defines.svh"

module dmem
    import platform_pkg::*;
(
    input  wire             clk_i,
    input  wire             rstn_i,

    input  wire             stb_i,
    input  wire             we_i,
    input  wire addr_t      addr_i,
    input  wire sel_t       sel_i,
    input  wire word_t      wdata_i,

    output word_t           rdata_o,
    output logic            ack_o
);

    localparam int IDX_W = $clog2(`DMEM_DEPTH_WORDS);

    word_t             mem [`DMEM_DEPTH_WORDS];
    logic [IDX_W-1:0]  idx;

    // word index, byte offset dropped
    assign idx = addr_i[IDX_W+1:2];

    // storage and read port
    always_ff @(posedge clk_i)
    begin
        if (stb_i && we_i)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (sel_i[b])
                begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end

        // old word, reads only
        rdata_o <= (stb_i && !we_i) ? mem[idx] : '0;
    end

    // one-cycle acknowledge
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            ack_o <= 1'b0;
        end
        else
        begin
            ack_o <= stb_i;
        end
    end

endmodule : dmem

`default_nettype wire

/* design/led_driver.sv */
// one 8-bit status register, aliased over its whole window
// only byte lane 0 is written, reads come back zero-extended
`timescale 1ns/10ps
`default_nettype none

module led_driver
    import platform_pkg::*;
(
    input  wire             clk_i,
    input  wire             rstn_i,

    input  wire             stb_i,
    input  wire             we_i,
    input  wire sel_t       sel_i,
    input  wire word_t      wdata_i,

    output word_t           rdata_o,
    output logic            ack_o,
    output led_t            led_status_o
);

    led_t led_q;
    logic wr_lane0;

    // write only takes effect with lane 0 enabled
    assign wr_lane0 = stb_i && we_i && sel_i[0];

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            led_q <= '0;
        end
        else if (wr_lane0)
        begin
            led_q <= wdata_i[7:0];
        end
    end

    // response, value before this cycle's write
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            ack_o   <= 1'b0;
            rdata_o <= '0;
        end
        else
        begin
            ack_o   <= stb_i;
            // zero on writes
            rdata_o <= (stb_i && !we_i) ? {24'h0, led_q} : '0;
        end
    end

    // pins follow the register directly
    assign led_status_o = led_q;

endmodule : led_driver

`default_nettype wire

/* design/mtimer.sv */
// mtime counts every clock, irq is level and stays high while mtime >= mtimecmp
// a write to mtime replaces that cycle's increment
`timescale 1ns/10ps
`default_nettype none

`include "platform_defines.svh"

module mtimer
    import platform_pkg::*;
(
    input  wire             clk_i,
    input  wire             rstn_i,

    input  wire             stb_i,
    input  wire             we_i,
    input  wire addr_t      addr_i,
    input  wire sel_t       sel_i,
    input  wire word_t      wdata_i,

    output word_t           rdata_o,
    output logic            ack_o,
    output logic            irq_timer_o
);

    logic [1:0] reg_idx;
    logic       wr;
    mtime_t     mtime_q;
    mtime_t     mtime_d;
    mtime_t     mtimecmp_q;
    mtime_t     mtimecmp_d;
    word_t      rd_word;

    // byte-enabled merge of one word
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (sel[b])
            begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign reg_idx = addr_i[3:2];
    assign wr      = stb_i && we_i;

    // next register values
    always_comb
    begin
        mtime_d    = mtime_q + 64'd1;
        mtimecmp_d = mtimecmp_q;

        if (wr)
        begin
            case (reg_idx)
                `MTIMER_IDX_MTIME_LO:
                    mtime_d = {mtime_q[63:32], merge_bytes(mtime_q[31:0], wdata_i, sel_i)};
                `MTIMER_IDX_MTIME_HI:
                    mtime_d = {merge_bytes(mtime_q[63:32], wdata_i, sel_i), mtime_q[31:0]};
                `MTIMER_IDX_MTIMECMP_LO:
                    mtimecmp_d[31:0] = merge_bytes(mtimecmp_q[31:0], wdata_i, sel_i);
                default:
                    mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], wdata_i, sel_i);
            endcase
        end
    end

    // read select, current values
    always_comb
    begin
        case (reg_idx)
            `MTIMER_IDX_MTIME_LO:    rd_word = mtime_q[31:0];
            `MTIMER_IDX_MTIME_HI:    rd_word = mtime_q[63:32];
            `MTIMER_IDX_MTIMECMP_LO: rd_word = mtimecmp_q[31:0];
            default:                 rd_word = mtimecmp_q[63:32];
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;
            irq_timer_o <= 1'b0;
            ack_o       <= 1'b0;
            rdata_o     <= '0;
        end
        else
        begin
            mtime_q     <= mtime_d;
            mtimecmp_q  <= mtimecmp_d;
            // compare on next values so irq moves with the write's ack
            irq_timer_o <= (mtime_d >= mtimecmp_d);
            ack_o       <= stb_i;
            rdata_o     <= (stb_i && !we_i) ? rd_word : '0;
        end
    end

endmodule : mtimer

`default_nettype wire

/* design/platform_pkg.sv */
// shared bus and target types of the data-side fabric
`default_nettype none

package platform_pkg;

    // data word on the bus
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // byte enables, one per lane
    typedef logic [3:0] sel_t;

    // led status value
    typedef logic [7:0] led_t;

    // timer counter and compare value
    typedef logic [63:0] mtime_t;

    // addressed target of a request
    // TGT_NONE doubles as idle and unmapped, the decoder keeps a valid bit beside it
    typedef enum logic [1:0]
    {
        TGT_DMEM,
        TGT_TIMER,
        TGT_LED,
        TGT_NONE
    } target_e;

endpackage : platform_pkg

`default_nettype wire

/* design/wb_addr_decoder.sv */
// no stall, every target must answer exactly one cycle after its strobe
// unmapped addresses complete with err instead of ack
`timescale 1ns/10ps
`default_nettype none

`include "platform_defines.svh"

module wb_addr_decoder
    import platform_pkg::*;
(
    input  wire             clk_i,
    input  wire             rstn_i,

    // master request side
    input  wire             m_cyc_i,
    input  wire             m_stb_i,
    input  wire addr_t      m_addr_i,

    // target responses
    input  wire word_t      dmem_rdata_i,
    input  wire             dmem_ack_i,
    input  wire word_t      tmr_rdata_i,
    input  wire             tmr_ack_i,
    input  wire word_t      led_rdata_i,
    input  wire             led_ack_i,

    // steered strobes, one-hot
    output logic            dmem_stb_o,
    output logic            tmr_stb_o,
    output logic            led_stb_o,

    // master response side
    output word_t           m_rdata_o,
    output logic            m_ack_o,
    output logic            m_err_o
);

    logic    req_acc;
    target_e tgt_d;
    target_e tgt_q;
    logic    valid_q;

    // accepted in every cycle with cyc and stb, no stall
    assign req_acc = m_cyc_i && m_stb_i;

    // later match wins, order dmem, timer, led
    always_comb
    begin
        tgt_d = TGT_NONE;

        if (req_acc)
        begin
            if ((m_addr_i & `DMEM_MASK) == `DMEM_BASE_ADDR)
            begin
                tgt_d = TGT_DMEM;
            end

            if ((m_addr_i & `MTIMER_MASK) == `MTIMER_BASE_ADDR)
            begin
                tgt_d = TGT_TIMER;
            end

            if ((m_addr_i & `LED_DRIVER_MASK) == `LED_DRIVER_BASE_ADDR)
            begin
                tgt_d = TGT_LED;
            end
        end
    end

    // strobes already carry the acceptance through tgt_d
    assign dmem_stb_o = (tgt_d == TGT_DMEM);
    assign tmr_stb_o  = (tgt_d == TGT_TIMER);
    assign led_stb_o  = (tgt_d == TGT_LED);

    // select for the response cycle
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            tgt_q   <= TGT_NONE;
            valid_q <= 1'b0;
        end
        else
        begin
            tgt_q   <= tgt_d;
            valid_q <= req_acc;
        end
    end

    // response mux
    always_comb
    begin
        m_rdata_o = '0;
        m_ack_o   = 1'b0;

        case (tgt_q)
            TGT_DMEM:
            begin
                m_rdata_o = dmem_rdata_i;
                m_ack_o   = dmem_ack_i;
            end
            TGT_TIMER:
            begin
                m_rdata_o = tmr_rdata_i;
                m_ack_o   = tmr_ack_i;
            end
            TGT_LED:
            begin
                m_rdata_o = led_rdata_i;
                m_ack_o   = led_ack_i;
            end
            default:
            begin
                m_rdata_o = '0;
                m_ack_o   = 1'b0;
            end
        endcase
    end

    // accepted but matched nothing
    assign m_err_o = valid_q && (tgt_q == TGT_NONE);

endmodule : wb_addr_decoder

`default_nettype wire

/* design/yarc_platform.sv */
// data-side fabric top, master ports stand in for the core's load/store unit
// no back-pressure, the master must take every response
`timescale 1ns/10ps
`default_nettype none

module yarc_platform
    import platform_pkg::*;
(
    input  wire             clk_i,
    input  wire             rstn_i,

    // load/store master
    input  wire             m_cyc_i,
    input  wire             m_stb_i,
    input  wire             m_we_i,
    input  wire addr_t      m_addr_i,
    input  wire sel_t       m_sel_i,
    input  wire word_t      m_wdata_i,
    output word_t           m_rdata_o,
    output logic            m_ack_o,
    output logic            m_err_o,

    // peripherals
    output led_t            led_status_o,
    output logic            irq_timer_o
);

    // steered strobes
    logic  dmem_stb;
    logic  tmr_stb;
    logic  led_stb;

    // target responses
    word_t dmem_rdata;
    logic  dmem_ack;
    word_t tmr_rdata;
    logic  tmr_ack;
    word_t led_rdata;
    logic  led_ack;

    wb_addr_decoder decoder_i
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .m_cyc_i      (m_cyc_i),
        .m_stb_i      (m_stb_i),
        .m_addr_i     (m_addr_i),
        .dmem_rdata_i (dmem_rdata),
        .dmem_ack_i   (dmem_ack),
        .tmr_rdata_i  (tmr_rdata),
        .tmr_ack_i    (tmr_ack),
        .led_rdata_i  (led_rdata),
        .led_ack_i    (led_ack),
        .dmem_stb_o   (dmem_stb),
        .tmr_stb_o    (tmr_stb),
        .led_stb_o    (led_stb),
        .m_rdata_o    (m_rdata_o),
        .m_ack_o      (m_ack_o),
        .m_err_o      (m_err_o)
    );

    // we, addr, sel and wdata fan out to every target
    dmem dmem_i
    (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .stb_i   (dmem_stb),
        .we_i    (m_we_i),
        .addr_i  (m_addr_i),
        .sel_i   (m_sel_i),
        .wdata_i (m_wdata_i),
        .rdata_o (dmem_rdata),
        .ack_o   (dmem_ack)
    );

    mtimer mtimer_i
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .stb_i       (tmr_stb),
        .we_i        (m_we_i),
        .addr_i      (m_addr_i),
        .sel_i       (m_sel_i),
        .wdata_i     (m_wdata_i),
        .rdata_o     (tmr_rdata),
        .ack_o       (tmr_ack),
        .irq_timer_o (irq_timer_o)
    );

    led_driver led_driver_i
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .stb_i        (led_stb),
        .we_i         (m_we_i),
        .sel_i        (m_sel_i),
        .wdata_i      (m_wdata_i),
        .rdata_o      (led_rdata),
        .ack_o        (led_ack),
        .led_status_o (led_status_o)
    );

endmodule : yarc_platform

`default_nettype wire

/* include/platform_defines.svh */
// address map and memory depth of the data-side fabric
// masks select the window, the low bits are the offset inside it
`ifndef PLATFORM_DEFINES_SVH
`define PLATFORM_DEFINES_SVH

// data memory, 4 KiB window
`define DMEM_BASE_ADDR          32'h0001_0000
`define DMEM_MASK               32'hFFFF_F000
// must fit the window, 1024 words of 4 bytes
`define DMEM_DEPTH_WORDS        1024

// machine timer, four word registers
`define MTIMER_BASE_ADDR        32'h0003_0000
`define MTIMER_MASK             32'hFFFF_FFF0

// word index inside the timer window, addr bits 3:2
`define MTIMER_IDX_MTIME_LO     2'd0
`define MTIMER_IDX_MTIME_HI     2'd1
`define MTIMER_IDX_MTIMECMP_LO  2'd2
`define MTIMER_IDX_MTIMECMP_HI  2'd3

// led status register, every offset aliases it
`define LED_DRIVER_BASE_ADDR    32'h0002_0000
`define LED_DRIVER_MASK         32'hFFFF_FFF0

`endif

/* sources.f */
+incdir+include
design/platform_pkg.sv
design/wb_addr_decoder.sv
design/dmem.sv
design/mtimer.sv
design/led_driver.sv
design/yarc_platform.sv
tests/tb_yarc_platform.sv

/* tests/tb_yarc_platform.sv */
// acts as the core's load/store unit, every response is checked one cycle after its request
// dmem lanes never written stay X in model and DUT alike, so reads compare with ===
`timescale 1ns/10ps
`default_nettype none

`include "platform_defines.svh"

module tb_yarc_platform
    import platform_pkg::*;
();

    localparam addr_t UNMAPPED_ADDR = 32'h0004_0000;
    localparam int    MEM_WRITES    = 64;
    localparam int    PIPE_READS    = 16;
    // mem, pipeline, led, timer, unmapped
    localparam int    TOTAL_REQS    = 2 * MEM_WRITES + PIPE_READS + 4 + 10 + 2;
    localparam int    CYCLE_LIMIT   = 2 * TOTAL_REQS + 200;

    logic  clk_i;
    logic  rstn_i;
    logic  m_cyc_i;
    logic  m_stb_i;
    logic  m_we_i;
    addr_t m_addr_i;
    sel_t  m_sel_i;
    word_t m_wdata_i;
    word_t m_rdata_o;
    logic  m_ack_o;
    logic  m_err_o;
    led_t  led_status_o;
    logic  irq_timer_o;

    // reference models
    word_t mem_model [`DMEM_DEPTH_WORDS];
    led_t  led_model;
    word_t mtime_hw;

    // expected responses, pushed at issue, popped one cycle later
    bit    exp_err_q [$];
    bit    exp_cmp_q [$];
    word_t exp_data_q [$];

    word_t last_rdata;
    int    written_idx [$];
    int    test_errs;
    int    pass_tests;
    int    fail_tests;
    int    cycle_count;

    yarc_platform uut
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .m_cyc_i      (m_cyc_i),
        .m_stb_i      (m_stb_i),
        .m_we_i       (m_we_i),
        .m_addr_i     (m_addr_i),
        .m_sel_i      (m_sel_i),
        .m_wdata_i    (m_wdata_i),
        .m_rdata_o    (m_rdata_o),
        .m_ack_o      (m_ack_o),
        .m_err_o      (m_err_o),
        .led_status_o (led_status_o),
        .irq_timer_o  (irq_timer_o)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        test_errs++;
    endtask

    // new byte lanes replace old ones where sel is set
    function automatic word_t merge_lanes(word_t old_w, word_t new_w, sel_t sel);
        word_t res;
        for (int b = 0; b < 4; b++)
        begin
            res[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic addr_t dmem_addr(int idx);
        return `DMEM_BASE_ADDR + (addr_t'(idx) << 2);
    endfunction

    // outputs settled since the last rising edge
    task automatic check_response();
        bit    want_err;
        bit    want_cmp;
        word_t want_data;
        if (exp_err_q.size() == 0)
        begin
            assert (!m_ack_o && !m_err_o)
                else report_problem("response seen with no request outstanding");
        end
        else
        begin
            want_err   = exp_err_q.pop_front();
            want_cmp   = exp_cmp_q.pop_front();
            want_data  = exp_data_q.pop_front();
            last_rdata = m_rdata_o;
            if (want_err)
            begin
                assert (!m_ack_o) else report_problem("ack returned where an error was expected");
                assert (m_err_o) else report_problem("no error returned for an unmapped address");
                assert (m_rdata_o == '0)
                    else report_mismatch($sformatf("rdata %h with err, expected 0", m_rdata_o));
            end
            else
            begin
                assert (m_ack_o) else report_problem("no ack one cycle after the request");
                assert (!m_err_o) else report_problem("err returned for a mapped address");
                if (want_cmp)
                begin
                    assert (m_rdata_o === want_data)
                        else report_mismatch($sformatf("rdata %h, expected %h",
                                                       m_rdata_o, want_data));
                end
            end
        end
    endtask

    // one request per falling edge, back-to-back when called in a row
    task automatic issue(input logic we, input addr_t addr, input sel_t sel, input word_t wdata,
                         input bit want_err, input bit want_cmp, input word_t want_data);
        @(negedge clk_i);
        check_response();
        m_cyc_i   = 1'b1;
        m_stb_i   = 1'b1;
        m_we_i    = we;
        m_addr_i  = addr;
        m_sel_i   = sel;
        m_wdata_i = wdata;
        exp_err_q.push_back(want_err);
        exp_cmp_q.push_back(want_cmp);
        exp_data_q.push_back(want_data);
    endtask

    task automatic idle();
        @(negedge clk_i);
        check_response();
        m_cyc_i = 1'b0;
        m_stb_i = 1'b0;
        m_we_i  = 1'b0;
    endtask

    // drain outstanding responses, then score the test
    task automatic finish_test(input string name);
        idle();
        idle();
        if (test_errs == 0)
        begin
            pass_tests++;
        end
        else
        begin
            fail_tests++;
        end
        $display("test %-10s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    // watchdog
    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        int    idx;
        sel_t  sel;
        word_t data;
        void'($urandom(32'h5c89_efe1));
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        m_cyc_i    = 1'b0;
        m_stb_i    = 1'b0;
        m_we_i     = 1'b0;
        m_addr_i   = '0;
        m_sel_i    = '0;
        m_wdata_i  = '0;
        led_model  = '0;
        test_errs  = 0;
        pass_tests = 0;
        fail_tests = 0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        // random byte-enabled writes, then read all back
        for (int i = 0; i < MEM_WRITES; i++)
        begin
            idx  = $urandom % `DMEM_DEPTH_WORDS;
            sel  = sel_t'($urandom_range(15, 0));
            data = $urandom;
            mem_model[idx] = merge_lanes(mem_model[idx], data, sel);
            written_idx.push_back(idx);
            issue(1'b1, dmem_addr(idx), sel, data, 1'b0, 1'b1, '0);
        end
        foreach (written_idx[i])
        begin
            issue(1'b0, dmem_addr(written_idx[i]), 4'hF, '0, 1'b0, 1'b1,
                  mem_model[written_idx[i]]);
        end
        finish_test("mem_bytes");

        // cyc and stb held high, acks on every following cycle in issue order
        for (int i = 0; i < PIPE_READS; i++)
        begin
            issue(1'b0, dmem_addr(written_idx[i]), 4'hF, '0, 1'b0, 1'b1,
                  mem_model[written_idx[i]]);
        end
        finish_test("pipeline");

        // led write with lane 0, then aliased readback
        data      = $urandom;
        sel       = sel_t'($urandom_range(15, 0)) | 4'b0001;
        led_model = data[7:0];
        issue(1'b1, `LED_DRIVER_BASE_ADDR, sel, data, 1'b0, 1'b1, '0);
        idle();
        idle();
        assert (led_status_o == led_model)
            else report_mismatch($sformatf("led %h, expected %h", led_status_o, led_model));
        issue(1'b0, `LED_DRIVER_BASE_ADDR + 4, 4'hF, '0, 1'b0, 1'b1, {24'h0, led_model});
        // lane 0 clear, register must hold
        data      = $urandom;
        data[7:0] = ~led_model;
        sel       = sel_t'($urandom_range(15, 0)) & 4'b1110;
        issue(1'b1, `LED_DRIVER_BASE_ADDR + 8, sel, data, 1'b0, 1'b1, '0);
        idle();
        idle();
        assert (led_status_o == led_model)
            else report_mismatch($sformatf("led %h changed, expected %h",
                                           led_status_o, led_model));
        issue(1'b0, `LED_DRIVER_BASE_ADDR, 4'hF, '0, 1'b0, 1'b1, {24'h0, led_model});
        finish_test("led_reg");

        // mtime moves by at least the gap between reads
        assert (!irq_timer_o) else report_mismatch("irq_timer_o high after reset");
        issue(1'b0, `MTIMER_BASE_ADDR, 4'hF, '0, 1'b0, 1'b0, '0);
        idle();
        mtime_hw = last_rdata;
        repeat (10) idle();
        issue(1'b0, `MTIMER_BASE_ADDR, 4'hF, '0, 1'b0, 1'b0, '0);
        idle();
        assert (last_rdata - mtime_hw >= 10)
            else report_mismatch($sformatf("mtime %h after %h, step below 10",
                                           last_rdata, mtime_hw));
        // mtimecmp to zero raises irq
        issue(1'b1, `MTIMER_BASE_ADDR + 8, 4'hF, '0, 1'b0, 1'b1, '0);
        issue(1'b1, `MTIMER_BASE_ADDR + 12, 4'hF, '0, 1'b0, 1'b1, '0);
        idle();
        idle();
        assert (irq_timer_o) else report_mismatch("irq_timer_o low with mtimecmp at 0");
        issue(1'b0, `MTIMER_BASE_ADDR + 8, 4'hF, '0, 1'b0, 1'b1, '0);
        issue(1'b0, `MTIMER_BASE_ADDR + 12, 4'hF, '0, 1'b0, 1'b1, '0);
        // back to all ones clears it
        issue(1'b1, `MTIMER_BASE_ADDR + 8, 4'hF, '1, 1'b0, 1'b1, '0);
        issue(1'b1, `MTIMER_BASE_ADDR + 12, 4'hF, '1, 1'b0, 1'b1, '0);
        idle();
        idle();
        assert (!irq_timer_o) else report_mismatch("irq_timer_o high with mtimecmp all ones");
        issue(1'b0, `MTIMER_BASE_ADDR + 8, 4'hF, '0, 1'b0, 1'b1, 32'hFFFF_FFFF);
        issue(1'b0, `MTIMER_BASE_ADDR + 12, 4'hF, '0, 1'b0, 1'b1, 32'hFFFF_FFFF);
        finish_test("timer");

        // err with zero data, next read unaffected
        issue(1'b0, UNMAPPED_ADDR, 4'hF, '0, 1'b1, 1'b0, '0);
        issue(1'b0, dmem_addr(written_idx[0]), 4'hF, '0, 1'b0, 1'b1,
              mem_model[written_idx[0]]);
        finish_test("unmapped");

        $display("tests: %0d passed, %0d failed", pass_tests, fail_tests);
        if (fail_tests == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_yarc_platform

`default_nettype wire
